// ==== design/byte_order_consts.svh ====
// Byte order constants

`ifndef BYTE_ORDER_CONSTS_SVH
`define BYTE_ORDER_CONSTS_SVH

// Bytes per data word
`define BOU_WORD_BYTES 4

// Word width in bits
`define BOU_WORD_BITS  32

// Opcode width, codes 4 to 7 are illegal
`define BOU_OPC_BITS   3

`endif

// ==== design/byte_order_pkg.sv ====
// Byte order types

`include "byte_order_consts.svh"

package byte_order_pkg;

    // Byte order opcodes
    typedef enum logic [`BOU_OPC_BITS-1:0] {
        OPC_PASS           = 3'd0,
        OPC_REV_BYTES      = 3'd1,
        OPC_SWAP_HALVES    = 3'd2,
        OPC_SWAP_IN_HALVES = 3'd3
    } bou_opcode_e;

    typedef logic [`BOU_WORD_BITS-1:0] bou_word_t;

    // Index of one byte within the word
    typedef logic [$clog2(`BOU_WORD_BYTES)-1:0] bou_byte_idx_t;

    // Entry k names the input byte that feeds output byte k
    typedef bou_byte_idx_t [`BOU_WORD_BYTES-1:0] bou_byte_map_t;

    // Decode stage to execute stage
    typedef struct packed {
        logic          valid;
        bou_word_t     data;
        bou_byte_map_t map;
        logic          illegal;
    } bou_dec_t;

    // Execute stage to result stage
    typedef struct packed {
        logic      valid;
        bou_word_t data;
        logic      illegal;
    } bou_exe_t;

endpackage

// ==== design/byte_order_decode.sv ====
// Byte order decode stage

`timescale 1ns/100ps

`include "byte_order_consts.svh"

module byte_order_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  byte_order_pkg::bou_opcode_e in_opcode,
    input  byte_order_pkg::bou_word_t   in_data,
    output byte_order_pkg::bou_dec_t    dec_stage
);

    import byte_order_pkg::*;

    logic          valid_q;
    bou_word_t     data_q;
    bou_byte_map_t map_q;
    logic          illegal_q;

    bou_byte_map_t map_next;
    logic          illegal_next;

    // True when no source index appears twice in the map
    function automatic logic map_is_perm(bou_byte_map_t m);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `BOU_WORD_BYTES; i++) begin
            for (int j = i + 1; j < `BOU_WORD_BYTES; j++) begin
                if (m[i] == m[j]) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Opcode to byte source map, illegal codes fall back to identity
    always_comb begin
        illegal_next = 1'b0;
        for (int k = 0; k < `BOU_WORD_BYTES; k++) begin
            map_next[k] = bou_byte_idx_t'(k);
        end
        case (in_opcode)
            OPC_PASS: begin
            end
            OPC_REV_BYTES: begin
                for (int k = 0; k < `BOU_WORD_BYTES; k++) begin
                    map_next[k] = bou_byte_idx_t'(`BOU_WORD_BYTES - 1 - k);
                end
            end
            OPC_SWAP_HALVES: begin
                for (int k = 0; k < `BOU_WORD_BYTES; k++) begin
                    map_next[k] = bou_byte_idx_t'(k ^ 2);
                end
            end
            OPC_SWAP_IN_HALVES: begin
                for (int k = 0; k < `BOU_WORD_BYTES; k++) begin
                    map_next[k] = bou_byte_idx_t'(k ^ 1);
                end
            end
            default: illegal_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Payload only loads with a new operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_q    <= in_data;
            map_q     <= map_next;
            illegal_q <= illegal_next;
        end
    end

    assign dec_stage = '{valid: valid_q, data: data_q, map: map_q, illegal: illegal_q};

    // Execute relies on a true permutation of the input bytes
    a_map_perm: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> map_is_perm(map_q));

endmodule

// ==== design/byte_order_execute.sv ====
// Byte order execute stage

`timescale 1ns/100ps

`include "byte_order_consts.svh"

module byte_order_execute (
    input  logic                     clk,
    input  logic                     rst_n,
    input  byte_order_pkg::bou_dec_t dec_stage,
    output byte_order_pkg::bou_exe_t exe_stage
);

    import byte_order_pkg::*;

    // Byte view of the incoming word
    logic [`BOU_WORD_BYTES-1:0][7:0] src_bytes;
    bou_word_t                       perm_data;

    logic      valid_q;
    bou_word_t data_q;
    logic      illegal_q;

    assign src_bytes = dec_stage.data;

    // One four-way byte mux per output lane
    always_comb begin
        for (int k = 0; k < `BOU_WORD_BYTES; k++) begin
            perm_data[k*8 +: 8] = src_bytes[dec_stage.map[k]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_stage.valid;
        end
    end

    // Idle cycles leave the data register untouched
    always_ff @(posedge clk) begin
        if (dec_stage.valid) begin
            data_q    <= perm_data;
            illegal_q <= dec_stage.illegal;
        end
    end

    assign exe_stage = '{valid: valid_q, data: data_q, illegal: illegal_q};

endmodule

// ==== design/byte_order_result.sv ====
// Byte order result stage

`timescale 1ns/100ps

`include "byte_order_consts.svh"

module byte_order_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  byte_order_pkg::bou_exe_t  exe_stage,
    output logic                      out_valid,
    output byte_order_pkg::bou_word_t out_data,
    output logic                      out_illegal
);

    // Strobe and flag follow the stage valid every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
        end else begin
            out_valid   <= exe_stage.valid;
            out_illegal <= exe_stage.valid & exe_stage.illegal;
        end
    end

    // Output word holds its last value between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data <= {`BOU_WORD_BITS{1'b0}};
        end else if (exe_stage.valid) begin
            out_data <= exe_stage.data;
        end
    end

    // Illegal flag arriving with a valid stage is fully known
    a_illegal_known: assert property (@(posedge clk) disable iff (!rst_n)
        exe_stage.valid |-> !$isunknown(exe_stage.illegal));

    // Every strobed word is fully known, so all earlier stages loaded cleanly
    a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_data));

endmodule

// ==== design/byte_order_unit.sv ====
// Byte order unit top level

`timescale 1ns/100ps

`include "byte_order_consts.svh"

module byte_order_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  byte_order_pkg::bou_opcode_e in_opcode,
    input  byte_order_pkg::bou_word_t   in_data,
    output logic                        out_valid,
    output byte_order_pkg::bou_word_t   out_data,
    output logic                        out_illegal
);

    import byte_order_pkg::*;

    bou_dec_t dec_stage;
    bou_exe_t exe_stage;

    // Opcode check and byte map
    byte_order_decode byte_order_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_opcode (in_opcode),
        .in_data   (in_data),
        .dec_stage (dec_stage)
    );

    // Byte permutation
    byte_order_execute byte_order_execute_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_stage (dec_stage),
        .exe_stage (exe_stage)
    );

    byte_order_result byte_order_result_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .exe_stage   (exe_stage),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_illegal (out_illegal)
    );

endmodule

// ==== test/byte_order_tb_util.svh ====
// Testbench helpers

`ifndef BYTE_ORDER_TB_UTIL_SVH
`define BYTE_ORDER_TB_UTIL_SVH

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Expected word, written out byte by byte from the opcode rules
function automatic bou_word_t ref_permute(bou_opcode_e op, bou_word_t w);
    logic [3:0][7:0] b;
    bou_word_t       r;
    b = w;
    case (op)
        // Output byte k takes input byte 3-k
        OPC_REV_BYTES:      r = {b[0], b[1], b[2], b[3]};
        // Output byte k takes input byte k xor 2
        OPC_SWAP_HALVES:    r = {b[1], b[0], b[3], b[2]};
        // Output byte k takes input byte k xor 1
        OPC_SWAP_IN_HALVES: r = {b[2], b[3], b[0], b[1]};
        // Pass and illegal codes leave the word alone
        default:            r = w;
    endcase
    return r;
endfunction

// Codes above the last legal opcode are flagged
function automatic logic ref_illegal(bou_opcode_e op);
    return (op >= 3'd4);
endfunction

task automatic compare_word(string test, bou_word_t expected, bou_word_t actual);
    if (actual !== expected) begin
        word_errors++;
        $display("FAILED %s: expected %h, actual %h", test, expected, actual);
    end
endtask

task automatic compare_flag(string test, logic expected, logic actual);
    if (actual !== expected) begin
        flag_errors++;
        $display("FAILED %s: expected %b, actual %b", test, expected, actual);
    end
endtask

`endif

// ==== test/byte_order_tb.sv ====
// Byte order unit testbench

`timescale 1ns/100ps

`include "byte_order_consts.svh"

module byte_order_tb;

    import byte_order_pkg::*;

    // Expected result and the monitor edge it has to show up on
    typedef struct packed {
        bou_word_t   data;
        logic        illegal;
        logic [31:0] due;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    bou_opcode_e in_opcode;
    bou_word_t   in_data;
    logic        out_valid;
    bou_word_t   out_data;
    logic        out_illegal;

    logic [31:0] cycle = 32'd0;
    logic [31:0] rng_state = 32'hbaa2_ce61;
    expect_t     exp_q[$];
    string       cur_test = "none";
    int          word_errors = 0;
    int          flag_errors = 0;
    int          other_errors = 0;

    `include "byte_order_tb_util.svh"

    byte_order_unit byte_order_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_opcode   (in_opcode),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_illegal (out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 32'd1;

    // Pops one expected entry per result strobe in order
    always @(posedge clk) begin
        expect_t e;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Result strobe in %s with no operation outstanding", cur_test);
            end else begin
                e = exp_q.pop_front();
                compare_word(cur_test, e.data, out_data);
                compare_flag(cur_test, e.illegal, out_illegal);
                if (cycle != e.due) begin
                    other_errors++;
                    $display("FAILED %s latency: expected cycle %0d, actual cycle %0d",
                             cur_test, e.due, cycle);
                end
            end
        end else if (rst_n && out_illegal) begin
            other_errors++;
            $display("Illegal flag raised in %s without a result strobe", cur_test);
        end
    end

    // Driven after edge d, sampled by decode on d+1, seen here three edges later
    task automatic send_op(bou_opcode_e op, bou_word_t data);
        expect_t e;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_opcode <= op;
        in_data   <= data;
        e.data    = ref_permute(op, data);
        e.illegal = ref_illegal(op);
        e.due     = cycle + 32'd4;
        exp_q.push_back(e);
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Timeout in %s: %0d results never arrived", cur_test, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic test_reset();
        cur_test = "reset";
        @(posedge clk);
        compare_flag(cur_test, 1'b0, out_valid);
        compare_flag(cur_test, 1'b0, out_illegal);
        compare_word(cur_test, '0, out_data);
    endtask

    task automatic check_fixed(bou_opcode_e op, bou_word_t expected);
        send_op(op, 32'h0123_4567);
        go_idle();
        wait_results();
        compare_word(cur_test, expected, out_data);
    endtask

    task automatic test_legal_fixed();
        cur_test = "legal opcodes";
        check_fixed(OPC_PASS, 32'h0123_4567);
        check_fixed(OPC_REV_BYTES, 32'h6745_2301);
        check_fixed(OPC_SWAP_HALVES, 32'h4567_0123);
        check_fixed(OPC_SWAP_IN_HALVES, 32'h2301_6745);
    endtask

    task automatic test_illegal();
        cur_test = "illegal opcodes";
        for (int code = 4; code < 8; code++) begin
            send_op(bou_opcode_e'(code[2:0]), next_random());
        end
        go_idle();
        wait_results();
    endtask

    // One operation per cycle while the monitor checks order and latency
    task automatic test_stream();
        logic [31:0] r;
        cur_test = "latency and throughput";
        for (int i = 0; i < 20; i++) begin
            r = next_random();
            send_op(bou_opcode_e'({1'b0, r[1:0]}), next_random());
        end
        go_idle();
        wait_results();
    endtask

    task automatic test_hold();
        bou_word_t w;
        bou_word_t held;
        cur_test = "hold";
        w = next_random();
        send_op(OPC_SWAP_HALVES, w);
        go_idle();
        wait_results();
        held = ref_permute(OPC_SWAP_HALVES, w);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            in_valid  <= 1'b0;
            in_opcode <= OPC_REV_BYTES;
            in_data   <= next_random();
            compare_word(cur_test, held, out_data);
            compare_flag(cur_test, 1'b0, out_valid);
        end
    endtask

    // Every legal permutation undoes itself
    task automatic test_involution();
        bou_word_t w;
        bou_word_t first;
        cur_test = "involution";
        for (int op = 0; op < 4; op++) begin
            w = next_random();
            send_op(bou_opcode_e'(op[2:0]), w);
            go_idle();
            wait_results();
            first = out_data;
            send_op(bou_opcode_e'(op[2:0]), first);
            go_idle();
            wait_results();
            compare_word(cur_test, w, out_data);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_opcode = OPC_PASS;
        in_data   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_legal_fixed();
        test_illegal();
        test_stream();
        test_hold();
        test_involution();
        repeat (4) @(posedge clk);
        $display("Errors: word %0d, flag %0d, other %0d", word_errors, flag_errors,
                 other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
+incdir+test
design/byte_order_pkg.sv
design/byte_order_decode.sv
design/byte_order_execute.sv
design/byte_order_result.sv
design/byte_order_unit.sv
test/byte_order_tb.sv

// ==== Makefile ====
TOP = byte_order_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
